/* hdl/svc_settings.svh */
// Service controller settings
// Command codes, local reset hold length, faulted bus address and clock default

`ifndef SVC_SETTINGS_SVH
`define SVC_SETTINGS_SVH

`default_nettype none

// Fuse-controller bus user select
`define SVC_CMD_AWUSER_CORE      8'h01
`define SVC_CMD_AWUSER_MCU       8'h02
`define SVC_CMD_AWUSER_RELEASE   8'h03

// Zeroization overrides
`define SVC_CMD_ZEROIZE_SET      8'h04
`define SVC_CMD_ZEROIZE_RESET    8'h05
`define SVC_CMD_ZEROIZE_RELEASE  8'h06

`define SVC_CMD_FORCE_TOKENS     8'h07
`define SVC_CMD_RMA_SCRAP_PPD    8'h08

// Escalation triggers
`define SVC_CMD_FC_ESCALATE      8'h09
`define SVC_CMD_ESC_SCRAP0       8'h0A
`define SVC_CMD_ESC_SCRAP1       8'h0B

// External clock selection
`define SVC_CMD_CLK_160MHZ       8'h0C
`define SVC_CMD_CLK_400MHZ       8'h0D
`define SVC_CMD_CLK_500MHZ       8'h0E
`define SVC_CMD_CLK_1000MHZ      8'h0F

`define SVC_CMD_FC_LCC_RESET     8'h10
`define SVC_CMD_FAULT_ARM        8'h11
`define SVC_CMD_SVA_DISABLE      8'h12
`define SVC_CMD_SVA_ENABLE       8'h13

// The local reset stays low for this count plus one cycles
`define SVC_RST_HOLD_CYCLES      10

`define SVC_FAULT_ADDR           32'h7000_0068
`define SVC_CLK_DEFAULT_MHZ      1000

`default_nettype wire

`endif

/* hdl/svc_pkg.sv */
// Service controller package
// Shared vector types, the override bundle and the reset pulser states

`default_nettype none

package svc_pkg;

  // --------------------
  // Vector types
  // --------------------

  typedef logic [7:0]  svc_cmd_t;
  typedef logic [10:0] svc_clk_mhz_t;
  typedef logic [31:0] svc_addr_t;
  typedef logic [31:0] svc_data_t;

  // --------------------
  // Override levels
  // --------------------

  typedef struct packed {
    // Bus user select for fuse-controller writes
    logic awuser_force;
    logic awuser_sel_mcu;
    // Zeroization group
    logic zeroize_force;
    logic fips_ppd;
    logic rom_mask_all;
    logic scrap_mode;
    // Life-cycle permissions
    logic tokens_force;
    logic rma_scrap_ppd;
    // Escalation triggers, sticky until reset
    logic fc_escalate;
    logic esc_scrap0;
    logic esc_scrap1;
    logic sva_disable;
  } svc_ovr_t;

  // Local reset pulser FSM
  typedef enum logic {
    IDLE,
    HOLD
  } svc_rst_state_t;

endpackage

`default_nettype wire

/* hdl/svc_cmd_decoder.sv */
// Service command decoder
// Turns command strobes into registered override levels and one-cycle start pulses

`timescale 1ns/1ps
`include "svc_settings.svh"
`default_nettype none

module svc_cmd_decoder (
  input  logic                   clk,
  input  logic                   cptra_rst_b,
  input  logic                   cmd_valid_i,
  input  svc_pkg::svc_cmd_t      cmd_i,
  output svc_pkg::svc_ovr_t      ovr_o,
  output logic                   rst_start_o,
  output logic                   clk_req_o,
  output svc_pkg::svc_clk_mhz_t  clk_mhz_o,
  output logic                   fault_arm_o
);

  import svc_pkg::*;

  svc_ovr_t     ovr_q;
  svc_clk_mhz_t clk_mhz_q;

  // --------------------
  // Override levels and pulses
  // --------------------

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      ovr_q       <= '0;
      rst_start_o <= 1'b0;
      clk_req_o   <= 1'b0;
      fault_arm_o <= 1'b0;
    end else begin
      // Pulses last a single cycle unless a command asserts them again
      rst_start_o <= 1'b0;
      clk_req_o   <= 1'b0;
      fault_arm_o <= 1'b0;
      if (cmd_valid_i) begin
        case (cmd_i)
          `SVC_CMD_AWUSER_CORE: begin
            ovr_q.awuser_force   <= 1'b1;
            ovr_q.awuser_sel_mcu <= 1'b0;
          end
          `SVC_CMD_AWUSER_MCU: begin
            ovr_q.awuser_force   <= 1'b1;
            ovr_q.awuser_sel_mcu <= 1'b1;
          end
          `SVC_CMD_AWUSER_RELEASE: begin
            ovr_q.awuser_force   <= 1'b0;
            ovr_q.awuser_sel_mcu <= 1'b0;
          end
          // Zeroization set raises PPD and the full ROM mask outside SCRAP mode
          `SVC_CMD_ZEROIZE_SET: begin
            ovr_q.zeroize_force <= 1'b1;
            ovr_q.fips_ppd      <= 1'b1;
            ovr_q.rom_mask_all  <= 1'b1;
            ovr_q.scrap_mode    <= 1'b0;
          end
          `SVC_CMD_ZEROIZE_RESET: begin
            ovr_q.zeroize_force <= 1'b1;
            ovr_q.fips_ppd      <= 1'b0;
            ovr_q.rom_mask_all  <= 1'b0;
            ovr_q.scrap_mode    <= 1'b1;
          end
          `SVC_CMD_ZEROIZE_RELEASE: begin
            ovr_q.zeroize_force <= 1'b0;
            ovr_q.fips_ppd      <= 1'b0;
            ovr_q.rom_mask_all  <= 1'b0;
            ovr_q.scrap_mode    <= 1'b0;
          end
          `SVC_CMD_FORCE_TOKENS:  ovr_q.tokens_force  <= 1'b1;
          `SVC_CMD_RMA_SCRAP_PPD: ovr_q.rma_scrap_ppd <= 1'b1;
          `SVC_CMD_FC_ESCALATE:   ovr_q.fc_escalate   <= 1'b1;
          `SVC_CMD_ESC_SCRAP0:    ovr_q.esc_scrap0    <= 1'b1;
          `SVC_CMD_ESC_SCRAP1:    ovr_q.esc_scrap1    <= 1'b1;
          `SVC_CMD_SVA_DISABLE:   ovr_q.sva_disable   <= 1'b1;
          `SVC_CMD_SVA_ENABLE:    ovr_q.sva_disable   <= 1'b0;
          `SVC_CMD_CLK_160MHZ,
          `SVC_CMD_CLK_400MHZ,
          `SVC_CMD_CLK_500MHZ,
          `SVC_CMD_CLK_1000MHZ:   clk_req_o           <= 1'b1;
          `SVC_CMD_FC_LCC_RESET:  rst_start_o         <= 1'b1;
          `SVC_CMD_FAULT_ARM:     fault_arm_o         <= 1'b1;
          default: begin
            // Unknown codes leave every output alone
          end
        endcase
      end
    end
  end

  // --------------------
  // Clock frequency
  // --------------------

  // Only meaningful while clk_req_o is high
  always_ff @(posedge clk) begin
    if (cmd_valid_i) begin
      case (cmd_i)
        `SVC_CMD_CLK_160MHZ:  clk_mhz_q <= 11'd160;
        `SVC_CMD_CLK_400MHZ:  clk_mhz_q <= 11'd400;
        `SVC_CMD_CLK_500MHZ:  clk_mhz_q <= 11'd500;
        `SVC_CMD_CLK_1000MHZ: clk_mhz_q <= 11'd1000;
        default: begin
        end
      endcase
    end
  end

  assign ovr_o     = ovr_q;
  assign clk_mhz_o = clk_mhz_q;

endmodule

`default_nettype wire

/* hdl/svc_reset_pulser.sv */
// Local reset pulser
// Holds the fuse-controller and life-cycle-controller reset low for a fixed time

`timescale 1ns/1ps
`include "svc_settings.svh"
`default_nettype none

module svc_reset_pulser (
  input  logic clk,
  input  logic cptra_rst_b,
  input  logic start_i,
  output logic rst_b_o
);

  import svc_pkg::*;

  svc_rst_state_t state_q;
  logic [3:0]     cnt_q;

  // --------------------
  // Hold FSM
  // --------------------

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      state_q <= IDLE;
      cnt_q   <= 4'd0;
    end else begin
      case (state_q)
        IDLE: begin
          if (start_i) begin
            state_q <= HOLD;
            cnt_q   <= 4'd0;
          end
        end
        HOLD: begin
          // A start during the hold is dropped, so the pulse never stretches
          if (cnt_q == 4'(`SVC_RST_HOLD_CYCLES)) begin
            state_q <= IDLE;
            cnt_q   <= 4'd0;
          end else begin
            cnt_q <= cnt_q + 4'd1;
          end
        end
        default: begin
          state_q <= IDLE;
          cnt_q   <= 4'd0;
        end
      endcase
    end
  end

  // Count runs 0 to SVC_RST_HOLD_CYCLES in HOLD, one more cycle than the setting
  assign rst_b_o = (state_q != HOLD);

endmodule

`default_nettype wire

/* hdl/svc_clk_switch.sv */
// External clock switch
// Holds the clock selection and a switch request that clears on bypass acknowledge

`timescale 1ns/1ps
`include "svc_settings.svh"
`default_nettype none

module svc_clk_switch (
  input  logic                   clk,
  input  logic                   cptra_rst_b,
  input  logic                   req_i,
  input  svc_pkg::svc_clk_mhz_t  mhz_i,
  input  logic                   byp_ack_i,
  output svc_pkg::svc_clk_mhz_t  sel_mhz_o,
  output logic                   switch_req_o
);

  import svc_pkg::*;

  svc_clk_mhz_t sel_q;
  logic         req_q;

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      sel_q <= 11'(`SVC_CLK_DEFAULT_MHZ);
      req_q <= 1'b0;
    end else begin
      if (req_i) begin
        // A fresh request wins over the clear of an old one
        sel_q <= mhz_i;
        req_q <= 1'b1;
      end else if (switch_req_o) begin
        req_q <= 1'b0;
      end
    end
  end

  // The request is only visible once the bypass path has acknowledged
  assign switch_req_o = req_q & byp_ack_i;
  assign sel_mhz_o    = sel_q;

endmodule

`default_nettype wire

/* hdl/svc_fault_inject.sv */
// Bus fault injector
// Once armed, flips bit 0 of write data going to the fixed fault address

`timescale 1ns/1ps
`include "svc_settings.svh"
`default_nettype none

module svc_fault_inject (
  input  logic               clk,
  input  logic               cptra_rst_b,
  input  logic               arm_i,
  input  logic               wr_i,
  input  svc_pkg::svc_addr_t addr_i,
  input  svc_pkg::svc_data_t wdata_i,
  output svc_pkg::svc_data_t wdata_o
);

  import svc_pkg::*;

  logic      armed_q;
  logic      hit;
  svc_data_t flip_mask;

  // Sticky until system reset
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      armed_q <= 1'b0;
    end else if (arm_i) begin
      armed_q <= 1'b1;
    end
  end

  // Zero-latency data path
  assign hit       = armed_q & wr_i & (addr_i == `SVC_FAULT_ADDR);
  assign flip_mask = {31'd0, hit};
  assign wdata_o   = wdata_i ^ flip_mask;

endmodule

`default_nettype wire

/* hdl/svc_ctrl_top.sv */
// Service controller top
// Connects the command decoder, reset pulser, clock switch and fault injector

`timescale 1ns/1ps
`default_nettype none

module svc_ctrl_top (
  input  logic                   clk,
  input  logic                   cptra_rst_b,
  input  logic                   cmd_valid_i,
  input  svc_pkg::svc_cmd_t      cmd_i,
  input  logic                   clk_byp_ack_i,
  input  logic                   bus_wr_i,
  input  svc_pkg::svc_addr_t     bus_addr_i,
  input  svc_pkg::svc_data_t     bus_wdata_i,
  output svc_pkg::svc_ovr_t      ovr_o,
  output logic                   fc_lcc_rst_b_o,
  output svc_pkg::svc_clk_mhz_t  clk_sel_mhz_o,
  output logic                   clk_switch_req_o,
  output svc_pkg::svc_data_t     bus_wdata_o
);

  logic                  rst_start;
  logic                  clk_req_pulse;
  svc_pkg::svc_clk_mhz_t clk_mhz;
  logic                  fault_arm;

  // --------------------
  // Command decode
  // --------------------

  svc_cmd_decoder i_svc_cmd_decoder (
    .clk         (clk),
    .cptra_rst_b (cptra_rst_b),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .ovr_o       (ovr_o),
    .rst_start_o (rst_start),
    .clk_req_o   (clk_req_pulse),
    .clk_mhz_o   (clk_mhz),
    .fault_arm_o (fault_arm)
  );

  // --------------------
  // Service blocks
  // --------------------

  svc_reset_pulser i_svc_reset_pulser (
    .clk         (clk),
    .cptra_rst_b (cptra_rst_b),
    .start_i     (rst_start),
    .rst_b_o     (fc_lcc_rst_b_o)
  );

  svc_clk_switch i_svc_clk_switch (
    .clk          (clk),
    .cptra_rst_b  (cptra_rst_b),
    .req_i        (clk_req_pulse),
    .mhz_i        (clk_mhz),
    .byp_ack_i    (clk_byp_ack_i),
    .sel_mhz_o    (clk_sel_mhz_o),
    .switch_req_o (clk_switch_req_o)
  );

  // Sits in the fuse-controller write data path
  svc_fault_inject i_svc_fault_inject (
    .clk         (clk),
    .cptra_rst_b (cptra_rst_b),
    .arm_i       (fault_arm),
    .wr_i        (bus_wr_i),
    .addr_i      (bus_addr_i),
    .wdata_i     (bus_wdata_i),
    .wdata_o     (bus_wdata_o)
  );

endmodule

`default_nettype wire

/* tests/svc_tb_clk.sv */
// Testbench clock source
// Free-running clock for the service controller testbench

`timescale 1ns/1ps
`default_nettype none

module svc_tb_clk #(
  parameter int PERIOD_NS = 100
) (
  output logic clk_o
);

  localparam int HALF_PERIOD_NS = PERIOD_NS / 2;

  initial begin
    clk_o = 1'b0;
  end

  always #(HALF_PERIOD_NS) clk_o = ~clk_o;

endmodule

`default_nettype wire

/* tests/svc_ctrl_chk.sv */
// Service controller checker
// Concurrent assertions on the local reset pulse, clock request and override outputs

`timescale 1ns/1ps
`include "svc_settings.svh"
`default_nettype none

module svc_ctrl_chk (
  input logic              clk,
  input logic              cptra_rst_b,
  input svc_pkg::svc_ovr_t ovr_i,
  input logic              fc_lcc_rst_b_i,
  input logic              clk_switch_req_i,
  input logic              clk_byp_ack_i
);

  logic [4:0] low_cnt_q;

  // Consecutive cycles with the local reset low
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      low_cnt_q <= 5'd0;
    end else if (!fc_lcc_rst_b_i) begin
      low_cnt_q <= low_cnt_q + 5'd1;
    end else begin
      low_cnt_q <= 5'd0;
    end
  end

  // --------------------
  // Properties
  // --------------------

  // On release the reset must have been low for the full hold time
  rst_hold_len: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    $rose(fc_lcc_rst_b_i) |-> (low_cnt_q == 5'(`SVC_RST_HOLD_CYCLES + 1)))
    else $error("Local reset released after %0d low cycles", low_cnt_q);

  clk_req_needs_ack: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    clk_switch_req_i |-> clk_byp_ack_i)
    else $error("Clock switch request seen without bypass acknowledge");

  ovr_zero_in_reset: assert property (@(posedge clk)
    (!cptra_rst_b && !$past(cptra_rst_b)) |-> (ovr_i == '0))
    else $error("Override levels not cleared during system reset");

endmodule

`default_nettype wire

/* tests/svc_ctrl_tb.sv */
// Service controller testbench
// Directed tests for overrides, local reset, clock switch and bus fault injection

`timescale 1ns/1ps
`include "svc_settings.svh"
`default_nettype none

module svc_ctrl_tb;

  import svc_pkg::*;

  // The directed tests finish well inside TEST_CYCLES and the limit doubles it
  localparam int TEST_CYCLES    = 200;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;
  localparam int RST_WINDOW     = `SVC_RST_HOLD_CYCLES + 6;

  logic         clk;
  logic         cptra_rst_b;
  logic         cmd_valid;
  svc_cmd_t     cmd;
  logic         clk_byp_ack;
  logic         bus_wr;
  svc_addr_t    bus_addr;
  svc_data_t    bus_wdata;
  svc_ovr_t     ovr;
  logic         fc_lcc_rst_b;
  svc_clk_mhz_t clk_sel_mhz;
  logic         clk_switch_req;
  svc_data_t    bus_wdata_out;
  svc_ovr_t     exp_ovr;
  int unsigned  cycle_cnt = 0;

  svc_tb_clk #(.PERIOD_NS(100)) i_svc_tb_clk (
    .clk_o (clk)
  );

  svc_ctrl_top i_svc_ctrl_top (
    .clk              (clk),
    .cptra_rst_b      (cptra_rst_b),
    .cmd_valid_i      (cmd_valid),
    .cmd_i            (cmd),
    .clk_byp_ack_i    (clk_byp_ack),
    .bus_wr_i         (bus_wr),
    .bus_addr_i       (bus_addr),
    .bus_wdata_i      (bus_wdata),
    .ovr_o            (ovr),
    .fc_lcc_rst_b_o   (fc_lcc_rst_b),
    .clk_sel_mhz_o    (clk_sel_mhz),
    .clk_switch_req_o (clk_switch_req),
    .bus_wdata_o      (bus_wdata_out)
  );

  bind svc_ctrl_top svc_ctrl_chk i_svc_ctrl_chk (
    .clk              (clk),
    .cptra_rst_b      (cptra_rst_b),
    .ovr_i            (ovr_o),
    .fc_lcc_rst_b_i   (fc_lcc_rst_b_o),
    .clk_switch_req_i (clk_switch_req_o),
    .clk_byp_ack_i    (clk_byp_ack_i)
  );

  // --------------------
  // Helpers
  // --------------------

  task check_value(input string name, input logic [31:0] actual, input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAIL t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, actual, expected);
      $display("SIMULATION FAILED");
      $fatal(1, "Stopping at first mismatch");
    end
  endtask

  // Returns on the edge that samples the command
  task send_cmd(input svc_cmd_t code);
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd       <= code;
    @(posedge clk);
    cmd_valid <= 1'b0;
  endtask

  task drive_write(input logic wr, input svc_addr_t addr, input svc_data_t data);
    @(posedge clk);
    bus_wr    <= wr;
    bus_addr  <= addr;
    bus_wdata <= data;
    @(negedge clk);
  endtask

  task apply_override(input svc_cmd_t code);
    send_cmd(code);
    @(negedge clk);
    check_value("ovr_o", 32'(ovr), 32'(exp_ovr));
  endtask

  // --------------------
  // Directed tests
  // --------------------

  task test_after_reset;
    @(negedge clk);
    check_value("ovr_o", 32'(ovr), 32'd0);
    check_value("fc_lcc_rst_b_o", 32'(fc_lcc_rst_b), 32'd1);
    check_value("clk_sel_mhz_o", 32'(clk_sel_mhz), 32'(`SVC_CLK_DEFAULT_MHZ));
    // With the acknowledge up only the request register can keep the output low
    @(posedge clk);
    clk_byp_ack <= 1'b1;
    @(negedge clk);
    check_value("clk_switch_req_o", 32'(clk_switch_req), 32'd0);
    @(posedge clk);
    clk_byp_ack <= 1'b0;
  endtask

  task test_overrides;
    exp_ovr.awuser_force   = 1'b1;
    exp_ovr.awuser_sel_mcu = 1'b1;
    apply_override(`SVC_CMD_AWUSER_MCU);
    exp_ovr.awuser_sel_mcu = 1'b0;
    apply_override(`SVC_CMD_AWUSER_CORE);
    exp_ovr.awuser_sel_mcu = 1'b1;
    apply_override(`SVC_CMD_AWUSER_MCU);
    exp_ovr.awuser_force   = 1'b0;
    exp_ovr.awuser_sel_mcu = 1'b0;
    apply_override(`SVC_CMD_AWUSER_RELEASE);
    exp_ovr.zeroize_force = 1'b1;
    exp_ovr.fips_ppd      = 1'b1;
    exp_ovr.rom_mask_all  = 1'b1;
    apply_override(`SVC_CMD_ZEROIZE_SET);
    exp_ovr.fips_ppd     = 1'b0;
    exp_ovr.rom_mask_all = 1'b0;
    exp_ovr.scrap_mode   = 1'b1;
    apply_override(`SVC_CMD_ZEROIZE_RESET);
    exp_ovr.zeroize_force = 1'b0;
    exp_ovr.scrap_mode    = 1'b0;
    apply_override(`SVC_CMD_ZEROIZE_RELEASE);
    // Release again from the set state so every group bit is seen clearing
    exp_ovr.zeroize_force = 1'b1;
    exp_ovr.fips_ppd      = 1'b1;
    exp_ovr.rom_mask_all  = 1'b1;
    apply_override(`SVC_CMD_ZEROIZE_SET);
    exp_ovr.zeroize_force = 1'b0;
    exp_ovr.fips_ppd      = 1'b0;
    exp_ovr.rom_mask_all  = 1'b0;
    apply_override(`SVC_CMD_ZEROIZE_RELEASE);
    exp_ovr.tokens_force = 1'b1;
    apply_override(`SVC_CMD_FORCE_TOKENS);
    exp_ovr.rma_scrap_ppd = 1'b1;
    apply_override(`SVC_CMD_RMA_SCRAP_PPD);
    exp_ovr.fc_escalate = 1'b1;
    apply_override(`SVC_CMD_FC_ESCALATE);
    exp_ovr.esc_scrap0 = 1'b1;
    apply_override(`SVC_CMD_ESC_SCRAP0);
    exp_ovr.esc_scrap1 = 1'b1;
    apply_override(`SVC_CMD_ESC_SCRAP1);
    exp_ovr.sva_disable = 1'b1;
    apply_override(`SVC_CMD_SVA_DISABLE);
    // An unknown code must leave every level where it was
    apply_override(8'hA5);
    exp_ovr.sva_disable = 1'b0;
    apply_override(`SVC_CMD_SVA_ENABLE);
  endtask

  // Cycle k counts from the edge that drives the command
  task check_reset_pulse(input int retrigger_k);
    int   k;
    logic exp_rst_b;
    send_cmd(`SVC_CMD_FC_LCC_RESET);
    for (k = 1; k <= RST_WINDOW; k++) begin
      @(negedge clk);
      exp_rst_b = !((k >= 2) && (k <= `SVC_RST_HOLD_CYCLES + 2));
      check_value("fc_lcc_rst_b_o", 32'(fc_lcc_rst_b), 32'(exp_rst_b));
      @(posedge clk);
      if (k == retrigger_k) begin
        cmd_valid <= 1'b1;
        cmd       <= `SVC_CMD_FC_LCC_RESET;
      end else begin
        cmd_valid <= 1'b0;
      end
    end
  endtask

  task test_local_reset;
    check_reset_pulse(0);
    // Second command lands in the middle of the hold
    check_reset_pulse(4);
  endtask

  task test_clock_switch;
    send_cmd(`SVC_CMD_CLK_400MHZ);
    @(posedge clk);
    @(negedge clk);
    check_value("clk_sel_mhz_o", 32'(clk_sel_mhz), 32'd400);
    check_value("clk_switch_req_o", 32'(clk_switch_req), 32'd0);
    @(posedge clk);
    clk_byp_ack <= 1'b1;
    @(negedge clk);
    check_value("clk_switch_req_o", 32'(clk_switch_req), 32'd1);
    @(negedge clk);
    check_value("clk_switch_req_o", 32'(clk_switch_req), 32'd0);
    check_value("clk_sel_mhz_o", 32'(clk_sel_mhz), 32'd400);
    @(posedge clk);
    clk_byp_ack <= 1'b0;
  endtask

  task test_fault_injection;
    svc_data_t data;
    data = $urandom;
    drive_write(1'b1, `SVC_FAULT_ADDR, data);
    check_value("bus_wdata_o", bus_wdata_out, data);
    send_cmd(`SVC_CMD_FAULT_ARM);
    data = $urandom;
    drive_write(1'b1, `SVC_FAULT_ADDR, data);
    check_value("bus_wdata_o", bus_wdata_out, {data[31:1], ~data[0]});
    data = $urandom;
    drive_write(1'b1, `SVC_FAULT_ADDR + 32'd4, data);
    check_value("bus_wdata_o", bus_wdata_out, data);
    data = $urandom;
    drive_write(1'b0, `SVC_FAULT_ADDR, data);
    check_value("bus_wdata_o", bus_wdata_out, data);
  endtask

  // --------------------
  // Run control
  // --------------------

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SIMULATION FAILED");
      $fatal(1, "Timeout");
    end
  end

  initial begin
    void'($urandom(28));
    cptra_rst_b = 1'b0;
    cmd_valid   = 1'b0;
    cmd         = '0;
    clk_byp_ack = 1'b0;
    bus_wr      = 1'b0;
    bus_addr    = '0;
    bus_wdata   = '0;
    exp_ovr     = '0;
    repeat (2) @(posedge clk);
    cptra_rst_b <= 1'b1;
    test_after_reset();
    test_overrides();
    test_local_reset();
    test_clock_switch();
    test_fault_injection();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+hdl
hdl/svc_pkg.sv
hdl/svc_cmd_decoder.sv
hdl/svc_reset_pulser.sv
hdl/svc_clk_switch.sv
hdl/svc_fault_inject.sv
hdl/svc_ctrl_top.sv
tests/svc_tb_clk.sv
tests/svc_ctrl_chk.sv
tests/svc_ctrl_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= svc_ctrl_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= SIMULATION PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
